/* hw/mips_pkg.sv */
package mips_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned data_w    = 32; // Data and address width
    localparam int unsigned byteen_w  = 4;  // One enable per byte lane
    localparam int unsigned hw_int_w  = 6;  // Core interrupt vector
    localparam int unsigned tc_addr_w = 2;  // Timer word offset
    localparam int unsigned tc_mode_w = 2;  // Timer mode field

    // Only a full word reaches the timer registers
    localparam logic [byteen_w-1:0] byteen_full = '1;

    ////////////////////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [data_w-1:0] dm_limit      = 32'h0000_3000; // First address past DM
    localparam logic [data_w-1:0] tc0_base      = 32'h0000_7F00;
    localparam logic [data_w-1:0] tc1_base      = 32'h0000_7F10;
    localparam logic [data_w-1:0] tc_span       = 32'd12;        // Three words per timer
    localparam logic [data_w-1:0] int_resp_addr = 32'h0000_7F20; // Interrupt responder

    // Timer register word offsets
    localparam logic [tc_addr_w-1:0] tc_ctrl_off   = 2'd0;
    localparam logic [tc_addr_w-1:0] tc_preset_off = 2'd1;
    localparam logic [tc_addr_w-1:0] tc_count_off  = 2'd2; // Read only

    ////////////////////////////////////////////////////////////////////////////
    // Timer control
    ////////////////////////////////////////////////////////////////////////////

    // Mode field values
    localparam logic [tc_mode_w-1:0] tc_mode_once   = 2'd0; // Count once, hold irq
    localparam logic [tc_mode_w-1:0] tc_mode_reload = 2'd1; // Auto reload, pulse irq

    // Ctrl bit positions
    localparam int unsigned ctrl_en_bit   = 0;
    localparam int unsigned ctrl_mode_lsb = 1; // Bits 2:1
    localparam int unsigned ctrl_im_bit   = 3; // Interrupt mask, 1 lets irq out

    // Timer FSM
    typedef enum logic [1:0] {
        tc_idle  = 2'd0, // Waiting for enable
        tc_load  = 2'd1, // Preset copied into count
        tc_count = 2'd2, // Counting down
        tc_fire  = 2'd3  // Interrupt state
    } tc_state_t;

endpackage

/* hw/data_bridge.sv */
`timescale 1ns/10ps

module data_bridge (
    // Core data port
    input  logic [mips_pkg::data_w-1:0]    cpu_data_addr,
    input  logic [mips_pkg::data_w-1:0]    cpu_data_wdata,
    input  logic [mips_pkg::byteen_w-1:0]  cpu_data_byteen,
    output logic [mips_pkg::data_w-1:0]    cpu_data_rdata,

    // Data memory side
    output logic [mips_pkg::data_w-1:0]    m_data_addr,
    output logic [mips_pkg::data_w-1:0]    m_data_wdata,
    output logic [mips_pkg::byteen_w-1:0]  m_data_byteen,
    input  logic [mips_pkg::data_w-1:0]    m_data_rdata,

    // Timer 0
    output logic [mips_pkg::tc_addr_w-1:0] tc0_addr,
    output logic [mips_pkg::data_w-1:0]    tc0_din,
    output logic                           tc0_we,
    input  logic [mips_pkg::data_w-1:0]    tc0_dout,

    // Timer 1
    output logic [mips_pkg::tc_addr_w-1:0] tc1_addr,
    output logic [mips_pkg::data_w-1:0]    tc1_din,
    output logic                           tc1_we,
    input  logic [mips_pkg::data_w-1:0]    tc1_dout
);

    logic                        sel_dm;    // Address inside data memory
    logic                        sel_tc0;   // Address inside timer 0 window
    logic                        sel_tc1;   // Address inside timer 1 window
    logic                        full_word; // All four lanes enabled
    logic [mips_pkg::data_w-1:0] tc0_off;   // Byte offset into timer 0
    logic [mips_pkg::data_w-1:0] tc1_off;   // Byte offset into timer 1

    //////////////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////////////

    assign sel_dm  = (cpu_data_addr < mips_pkg::dm_limit);
    assign sel_tc0 = (cpu_data_addr >= mips_pkg::tc0_base) &&
                     (cpu_data_addr <  mips_pkg::tc0_base + mips_pkg::tc_span);
    assign sel_tc1 = (cpu_data_addr >= mips_pkg::tc1_base) &&
                     (cpu_data_addr <  mips_pkg::tc1_base + mips_pkg::tc_span);

    assign full_word = (cpu_data_byteen == mips_pkg::byteen_full);

    // Offsets within each window
    assign tc0_off = cpu_data_addr - mips_pkg::tc0_base;
    assign tc1_off = cpu_data_addr - mips_pkg::tc1_base;

    //////////////////////////////////////////////////////////////////////////////
    // Write steering
    //////////////////////////////////////////////////////////////////////////////

    // Memory sees address and data always, lanes only when selected
    assign m_data_addr   = cpu_data_addr;
    assign m_data_wdata  = cpu_data_wdata;
    assign m_data_byteen = sel_dm ? cpu_data_byteen : '0;

    // Word address drops the byte bits
    assign tc0_addr = tc0_off[mips_pkg::tc_addr_w+1:2];
    assign tc0_din  = cpu_data_wdata;
    assign tc0_we   = sel_tc0 && full_word; // Partial writes ignored

    assign tc1_addr = tc1_off[mips_pkg::tc_addr_w+1:2];
    assign tc1_din  = cpu_data_wdata;
    assign tc1_we   = sel_tc1 && full_word;

    //////////////////////////////////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (sel_dm) begin
            cpu_data_rdata = m_data_rdata;
        end else if (sel_tc0) begin
            cpu_data_rdata = tc0_dout;
        end else if (sel_tc1) begin
            cpu_data_rdata = tc1_dout;
        end else begin
            cpu_data_rdata = '0; // Unmapped reads as zero
        end
    end

endmodule

/* hw/timer_counter.sv */
`timescale 1ns/10ps

module timer_counter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           we,    // Full word write strobe
    input  logic [mips_pkg::tc_addr_w-1:0] addr,  // Word offset
    input  logic [mips_pkg::data_w-1:0]    din,
    output logic [mips_pkg::data_w-1:0]    dout,
    output logic                           irq
);

    logic [mips_pkg::data_w-1:0] ctrl;    // Enable, mode, mask
    logic [mips_pkg::data_w-1:0] preset;  // Reload value
    logic [mips_pkg::data_w-1:0] count;   // Current count, read only
    mips_pkg::tc_state_t         state;

    logic ctrl_wr;
    logic preset_wr;
    logic en;
    logic reload;
    logic count_zero;
    logic done;      // Last counting cycle

    //////////////////////////////////////////////////////////////////////////////
    // Decode of register fields
    //////////////////////////////////////////////////////////////////////////////

    assign ctrl_wr   = we && (addr == mips_pkg::tc_ctrl_off);
    assign preset_wr = we && (addr == mips_pkg::tc_preset_off);

    assign en     = ctrl[mips_pkg::ctrl_en_bit];
    assign reload = (ctrl[mips_pkg::ctrl_mode_lsb +: mips_pkg::tc_mode_w]
                     == mips_pkg::tc_mode_reload); // Other codes act as once

    assign count_zero = (count == '0);
    assign done       = (state == mips_pkg::tc_count) && en && count_zero;

    //////////////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mips_pkg::tc_idle;
        end else if (ctrl_wr && (state == mips_pkg::tc_fire)) begin
            state <= mips_pkg::tc_idle; // Ctrl write acknowledges
        end else begin
            case (state)
                mips_pkg::tc_idle: begin
                    if (en) begin
                        state <= mips_pkg::tc_load;
                    end
                end
                mips_pkg::tc_load: begin
                    // Dropping enable aborts the run
                    state <= en ? mips_pkg::tc_count : mips_pkg::tc_idle;
                end
                mips_pkg::tc_count: begin
                    if (!en) begin
                        state <= mips_pkg::tc_idle;
                    end else if (count_zero) begin
                        state <= mips_pkg::tc_fire;
                    end
                end
                mips_pkg::tc_fire: begin
                    if (reload) begin
                        state <= mips_pkg::tc_load; // One cycle pulse
                    end
                    // Once mode waits here for a ctrl write
                end
                default: begin
                    state <= mips_pkg::tc_idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////////////

    // Ctrl, bus write wins over the self clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else if (ctrl_wr) begin
            ctrl <= din;
        end else if (done && !reload) begin
            ctrl[mips_pkg::ctrl_en_bit] <= 1'b0; // One shot disarms
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            preset <= '0;
        end else if (preset_wr) begin
            preset <= din;
        end
    end

    // Count loads in load state and stops at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (state == mips_pkg::tc_load) begin
            count <= preset;
        end else if ((state == mips_pkg::tc_count) && en && !count_zero) begin
            count <= count - 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (addr)
            mips_pkg::tc_ctrl_off:   dout = ctrl;
            mips_pkg::tc_preset_off: dout = preset;
            mips_pkg::tc_count_off:  dout = count;
            default:                 dout = '0; // Fourth word unused
        endcase
    end

    // Masked by im bit
    assign irq = (state == mips_pkg::tc_fire) && ctrl[mips_pkg::ctrl_im_bit];

endmodule

/* hw/int_collector.sv */
`timescale 1ns/10ps

module int_collector (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          interrupt,     // Asynchronous pin
    input  logic                          tc0_irq,
    input  logic                          tc1_irq,
    input  logic                          ig_response,   // Core response strobe
    input  logic [mips_pkg::byteen_w-1:0] m_data_byteen,
    output logic [mips_pkg::hw_int_w-1:0] hw_int,
    output logic [mips_pkg::data_w-1:0]   m_int_addr,
    output logic [mips_pkg::byteen_w-1:0] m_int_byteen
);

    logic int_meta;  // First sync stage
    logic int_sync;  // Safe to use in clk domain
    logic resp_hit;  // Response while interrupt asserted

    //////////////////////////////////////////////////////////////////////////////
    // Pin synchronizer
    //////////////////////////////////////////////////////////////////////////////

    // Two flops, bit 2 follows the pin two edges later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_meta <= 1'b0;
            int_sync <= 1'b0;
        end else begin
            int_meta <= interrupt;
            int_sync <= int_meta;
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Vector and responder
    //////////////////////////////////////////////////////////////////////////////

    // Upper bits unused
    assign hw_int = {{(mips_pkg::hw_int_w-3){1'b0}}, int_sync, tc0_irq, tc1_irq};

    assign resp_hit = ig_response && int_sync;

    // Responder write only on a matching response
    assign m_int_addr   = resp_hit ? mips_pkg::int_resp_addr : '0;
    assign m_int_byteen = resp_hit ? m_data_byteen : '0;

endmodule

/* hw/mips_periph_top.sv */
`timescale 1ns/10ps

module mips_periph_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          interrupt,       // External pin
    input  logic                          ig_response,     // From core
    input  logic [mips_pkg::data_w-1:0]   cpu_data_addr,
    input  logic [mips_pkg::data_w-1:0]   cpu_data_wdata,
    input  logic [mips_pkg::byteen_w-1:0] cpu_data_byteen,
    output logic [mips_pkg::data_w-1:0]   cpu_data_rdata,
    output logic [mips_pkg::hw_int_w-1:0] hw_int,          // To core
    output logic [mips_pkg::data_w-1:0]   m_data_addr,
    output logic [mips_pkg::data_w-1:0]   m_data_wdata,
    output logic [mips_pkg::byteen_w-1:0] m_data_byteen,
    input  logic [mips_pkg::data_w-1:0]   m_data_rdata,
    output logic [mips_pkg::data_w-1:0]   m_int_addr,
    output logic [mips_pkg::byteen_w-1:0] m_int_byteen
);

    // Bridge to timer 0
    logic [mips_pkg::tc_addr_w-1:0] tc0_addr;
    logic [mips_pkg::data_w-1:0]    tc0_din;
    logic                           tc0_we;
    logic [mips_pkg::data_w-1:0]    tc0_dout;
    logic                           tc0_irq;

    // Bridge to timer 1, own signals
    logic [mips_pkg::tc_addr_w-1:0] tc1_addr;
    logic [mips_pkg::data_w-1:0]    tc1_din;
    logic                           tc1_we;
    logic [mips_pkg::data_w-1:0]    tc1_dout;
    logic                           tc1_irq;

    //////////////////////////////////////////////////////////////////////////////
    // Bus side
    //////////////////////////////////////////////////////////////////////////////

    data_bridge bridge (
        .cpu_data_addr   (cpu_data_addr),
        .cpu_data_wdata  (cpu_data_wdata),
        .cpu_data_byteen (cpu_data_byteen),
        .cpu_data_rdata  (cpu_data_rdata),
        .m_data_addr     (m_data_addr),
        .m_data_wdata    (m_data_wdata),
        .m_data_byteen   (m_data_byteen),
        .m_data_rdata    (m_data_rdata),
        .tc0_addr        (tc0_addr),
        .tc0_din         (tc0_din),
        .tc0_we          (tc0_we),
        .tc0_dout        (tc0_dout),
        .tc1_addr        (tc1_addr),
        .tc1_din         (tc1_din),
        .tc1_we          (tc1_we),
        .tc1_dout        (tc1_dout)
    );

    //////////////////////////////////////////////////////////////////////////////
    // Timers and interrupts
    //////////////////////////////////////////////////////////////////////////////

    timer_counter tc0 (.clk(clk), .rst_n(rst_n), .we(tc0_we), .addr(tc0_addr),
                       .din(tc0_din), .dout(tc0_dout), .irq(tc0_irq));

    timer_counter tc1 (.clk(clk), .rst_n(rst_n), .we(tc1_we), .addr(tc1_addr),
                       .din(tc1_din), .dout(tc1_dout), .irq(tc1_irq));

    int_collector intc (
        .clk           (clk),
        .rst_n         (rst_n),
        .interrupt     (interrupt),
        .tc0_irq       (tc0_irq),
        .tc1_irq       (tc1_irq),
        .ig_response   (ig_response),
        .m_data_byteen (m_data_byteen), // Gated lanes from bridge
        .hw_int        (hw_int),
        .m_int_addr    (m_int_addr),
        .m_int_byteen  (m_int_byteen)
    );

endmodule

/* tb/mips_periph_assertions.sv */
`timescale 1ns/10ps

module mips_periph_assertions (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           sel_dm,    // Bridge selects
    input logic                           sel_tc0,
    input logic                           sel_tc1,
    input logic [mips_pkg::byteen_w-1:0]  byteen,    // Core lanes before gating
    input logic                           tc0_we,
    input logic                           tc1_we,
    input logic [mips_pkg::hw_int_w-1:0]  hw_int,    // Vector seen by the core
    input logic [mips_pkg::data_w-1:0]    tc0_ctrl,
    input logic [mips_pkg::data_w-1:0]    tc1_ctrl,
    input mips_pkg::tc_state_t            tc0_state,
    input mips_pkg::tc_state_t            tc1_state
);

    ////////////////////////////////////////////////////////////////////////////
    // Bridge
    ////////////////////////////////////////////////////////////////////////////

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({sel_dm, sel_tc0, sel_tc1}))
        else $error("more than one bridge select active");

    // Timer registers take full words only
    a_no_partial: assert property (@(posedge clk) disable iff (!rst_n)
        (byteen != mips_pkg::byteen_full) |-> !(tc0_we || tc1_we))
        else $error("timer write strobe on a partial byte enable");

    ////////////////////////////////////////////////////////////////////////////
    // Timers
    ////////////////////////////////////////////////////////////////////////////

    // Timer 0 drives bit 1 and timer 1 drives bit 0 of the core vector
    a_tc0_mask: assert property (@(posedge clk) disable iff (!rst_n)
        hw_int[1] |-> (tc0_ctrl[mips_pkg::ctrl_im_bit] && (tc0_state == mips_pkg::tc_fire)))
        else $error("timer 0 interrupt reached the core while masked or outside fire");

    a_tc1_mask: assert property (@(posedge clk) disable iff (!rst_n)
        hw_int[0] |-> (tc1_ctrl[mips_pkg::ctrl_im_bit] && (tc1_state == mips_pkg::tc_fire)))
        else $error("timer 1 interrupt reached the core while masked or outside fire");

endmodule

bind mips_periph_top mips_periph_assertions chk (
    .clk(clk), .rst_n(rst_n),
    .sel_dm(bridge.sel_dm), .sel_tc0(bridge.sel_tc0), .sel_tc1(bridge.sel_tc1),
    .byteen(cpu_data_byteen), .tc0_we(tc0_we), .tc1_we(tc1_we),
    .hw_int(hw_int), .tc0_ctrl(tc0.ctrl), .tc1_ctrl(tc1.ctrl),
    .tc0_state(tc0.state), .tc1_state(tc1.state)
);

/* tb/tb_mips_periph.sv */
`timescale 1ns/10ps

module tb_mips_periph;

    logic                          clk;
    logic                          rst_n;
    logic                          interrupt;
    logic                          ig_response;
    logic [mips_pkg::data_w-1:0]   cpu_data_addr;
    logic [mips_pkg::data_w-1:0]   cpu_data_wdata;
    logic [mips_pkg::byteen_w-1:0] cpu_data_byteen;
    logic [mips_pkg::data_w-1:0]   cpu_data_rdata;
    logic [mips_pkg::hw_int_w-1:0] hw_int;
    logic [mips_pkg::data_w-1:0]   m_data_addr;
    logic [mips_pkg::data_w-1:0]   m_data_wdata;
    logic [mips_pkg::byteen_w-1:0] m_data_byteen;
    logic [mips_pkg::data_w-1:0]   m_data_rdata;   // Played by the testbench
    logic [mips_pkg::data_w-1:0]   m_int_addr;
    logic [mips_pkg::byteen_w-1:0] m_int_byteen;

    integer                        seed;
    int                            n_checks;
    int                            n_errors;
    int                            test_base;      // Error count at test start
    string                         cur_test;
    bit                            chk_en;         // Compare process armed
    logic [mips_pkg::data_w-1:0]   idle_addr;      // Unmapped address that reads as zero
    logic [mips_pkg::data_w-1:0]   model_regs [2][3]; // Ctrl, preset and count per timer

    mips_periph_top dut0 (.*);

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Model and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [mips_pkg::data_w-1:0] tc_base(input int t);
        return (t == 0) ? mips_pkg::tc0_base : mips_pkg::tc1_base;
    endfunction

    function automatic logic [mips_pkg::data_w-1:0] ctrl_word(input logic en,
            input logic [1:0] mode, input logic im);
        return (32'(im) << mips_pkg::ctrl_im_bit) | (32'(mode) << mips_pkg::ctrl_mode_lsb) |
               (32'(en) << mips_pkg::ctrl_en_bit);
    endfunction

    // Expected read data from the address map
    function automatic logic [mips_pkg::data_w-1:0] ref_read(
            input logic [mips_pkg::data_w-1:0] addr);
        logic [mips_pkg::data_w-1:0] off;
        if (addr < mips_pkg::dm_limit) begin
            return m_data_rdata;
        end
        for (int t = 0; t < 2; t++) begin
            if (addr >= tc_base(t) && addr < tc_base(t) + mips_pkg::tc_span) begin
                off = (addr - tc_base(t)) >> 2;
                return model_regs[t][off];
            end
        end
        return '0;
    endfunction

    task automatic check_word(input string name, input logic [mips_pkg::data_w-1:0] exp,
            input logic [mips_pkg::data_w-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_byteen(input string name, input logic [mips_pkg::byteen_w-1:0] exp,
            input logic [mips_pkg::byteen_w-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_vec(input string name, input logic [mips_pkg::hw_int_w-1:0] exp,
            input logic [mips_pkg::hw_int_w-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Bridge outputs every cycle and read data on read cycles
    always @(negedge clk) begin
        if (chk_en) begin
            check_word({cur_test, " m_data_addr"}, cpu_data_addr, m_data_addr);
            check_word({cur_test, " m_data_wdata"}, cpu_data_wdata, m_data_wdata);
            check_byteen({cur_test, " m_data_byteen"},
                         (cpu_data_addr < mips_pkg::dm_limit) ? cpu_data_byteen : '0,
                         m_data_byteen);
            if (cpu_data_byteen == '0) begin
                check_word({cur_test, " rdata"}, ref_read(cpu_data_addr), cpu_data_rdata);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Core side driver
    ////////////////////////////////////////////////////////////////////////////

    // Drives one bus cycle and returns on the commit edge
    task automatic bus_access(input logic [mips_pkg::data_w-1:0] addr,
            input logic [mips_pkg::data_w-1:0] data, input logic [mips_pkg::byteen_w-1:0] be);
        @(posedge clk);
        cpu_data_addr   <= addr;
        cpu_data_wdata  <= data;
        cpu_data_byteen <= be;
        m_data_rdata    <= $random(seed);
        for (int t = 0; t < 2; t++) begin
            if (be == mips_pkg::byteen_full && addr >= tc_base(t) &&
                addr < tc_base(t) + mips_pkg::tc_count_off * 4) begin
                model_regs[t][(addr - tc_base(t)) >> 2] = data; // Count is read only
            end
        end
        @(posedge clk);
        cpu_data_addr   <= idle_addr;
        cpu_data_byteen <= '0;
    endtask

    // Cycles counted at negedges from zero
    task automatic wait_bit(input int idx, input logic level, input int limit,
            output int cycles, output bit ok);
        ok = 0;
        cycles = 0;
        while (!ok && cycles <= limit) begin
            @(negedge clk);
            if (hw_int[idx] === level) ok = 1;
            else cycles++;
        end
        if (!ok) begin
            n_errors++;
            $display("%s: timeout waiting for hw_int[%0d] to reach %0b", cur_test, idx, level);
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_base = n_errors;
    endtask

    task automatic end_test();
        $display("%s: %s (%0d errors)", cur_test,
                 (n_errors == test_base) ? "ok" : "errors seen", n_errors - test_base);
    endtask

    // Watchdog against a stuck run
    initial begin
        repeat (50000) @(posedge clk);
        $display("simulation stuck, watchdog expired");
        $display("test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int p;
        int cyc;
        int pulses;
        bit ok;
        logic prev;
        logic [mips_pkg::data_w-1:0] a;
        logic [mips_pkg::data_w-1:0] v;
        logic [mips_pkg::byteen_w-1:0] be;
        seed = 32'he61e_d255;
        clk = 0;
        rst_n = 0;
        interrupt = 0;
        ig_response = 0;
        idle_addr = 32'h0000_5000;
        cpu_data_addr = idle_addr;
        cpu_data_wdata = '0;
        cpu_data_byteen = '0;
        m_data_rdata = '0;
        n_checks = 0;
        n_errors = 0;
        chk_en = 0;
        for (int t = 0; t < 2; t++) begin
            for (int w = 0; w < 3; w++) begin
                model_regs[t][w] = '0;
            end
        end
        repeat (3) @(posedge clk);
        rst_n <= 1;
        @(negedge clk);
        chk_en = 1;

        start_test("reset");
        check_vec("reset hw_int", '0, hw_int);
        check_word("reset m_int_addr", '0, m_int_addr);
        check_byteen("reset m_int_byteen", '0, m_int_byteen);
        for (int t = 0; t < 2; t++) begin
            for (int w = 0; w < 3; w++) begin
                bus_access(tc_base(t) + 4 * w, '0, '0); // Timer registers read back zero
            end
        end
        end_test();

        start_test("memory");
        for (int k = 0; k < 16; k++) begin
            a = {$random(seed)} % mips_pkg::dm_limit;
            a[1:0] = 2'b00;
            be = $random(seed);
            bus_access(a, $random(seed), be);
            bus_access(a, $random(seed), '0);          // Read back DM data
        end
        bus_access(mips_pkg::tc0_base + 4, $random(seed), 4'b0011); // Timer range gets no DM lanes
        bus_access(idle_addr, $random(seed), mips_pkg::byteen_full);
        bus_access(32'h0000_7F0C, $random(seed), mips_pkg::byteen_full); // Gap after timer 0
        bus_access(32'h0000_7F0C, '0, '0);
        bus_access(mips_pkg::int_resp_addr, '0, '0);
        end_test();

        start_test("timer regs");
        for (int t = 0; t < 2; t++) begin
            v = $random(seed);
            v[mips_pkg::ctrl_en_bit] = 1'b0;          // Keep the timer idle
            bus_access(tc_base(t), v, mips_pkg::byteen_full);
            bus_access(tc_base(t) + 4, $random(seed), mips_pkg::byteen_full);
            bus_access(tc_base(t), ~v, 4'b0111);      // Partial write must be dropped
            bus_access(tc_base(t) + 4, $random(seed), 4'b1000);
            for (int u = 0; u < 2; u++) begin
                bus_access(tc_base(u), '0, '0);
                bus_access(tc_base(u) + 4, '0, '0);
            end
        end
        end_test();

        start_test("one-shot");
        for (int t = 0; t < 2; t++) begin
            p = {$random(seed)} % 16 + 1;
            bus_access(tc_base(t) + 4, p, mips_pkg::byteen_full);
            bus_access(tc_base(t), ctrl_word(1'b1, mips_pkg::tc_mode_once, 1'b1),
                       mips_pkg::byteen_full);
            wait_bit(1 - t, 1'b1, p + 20, cyc, ok);
            if (ok) check_word("one-shot latency", p + 3, cyc);
            model_regs[t][0][mips_pkg::ctrl_en_bit] = 1'b0; // Disarmed on fire
            model_regs[t][2] = '0;
            repeat (4) begin
                @(negedge clk);
                check_vec("one-shot hold", 6'(1 << (1 - t)), hw_int);
            end
            bus_access(tc_base(t), '0, '0);
            bus_access(tc_base(t) + 8, '0, '0);
            bus_access(tc_base(t), ctrl_word(1'b0, mips_pkg::tc_mode_once, 1'b1),
                       mips_pkg::byteen_full);
            @(negedge clk);
            check_vec("one-shot clear", '0, hw_int);
        end
        end_test();

        start_test("reload");
        for (int t = 0; t < 2; t++) begin
            p = {$random(seed)} % 8 + 1;
            bus_access(tc_base(t) + 4, p, mips_pkg::byteen_full);
            bus_access(tc_base(t), ctrl_word(1'b1, mips_pkg::tc_mode_reload, 1'b1),
                       mips_pkg::byteen_full);
            pulses = 0;
            prev = 1'b0;
            for (int k = 0; k < 2 * (p + 20) && pulses < 2; k++) begin
                @(negedge clk);
                if (hw_int[1 - t] && prev) begin
                    n_errors++;
                    $display("%s: timer %0d irq pulse longer than one cycle", cur_test, t);
                end
                if (hw_int[1 - t] && !prev) pulses++;
                prev = hw_int[1 - t];
            end
            if (pulses < 2) begin
                n_errors++;
                $display("%s: timeout, timer %0d gave %0d pulses", cur_test, t, pulses);
            end
            // No pulse may appear with the mask clear
            bus_access(tc_base(t), ctrl_word(1'b1, mips_pkg::tc_mode_reload, 1'b0),
                       mips_pkg::byteen_full);
            for (int k = 0; k < 3 * (p + 3) + 10; k++) begin
                @(negedge clk);
                check_vec("reload masked", '0, hw_int);
            end
            bus_access(tc_base(t), '0, mips_pkg::byteen_full);
        end
        end_test();

        start_test("external irq");
        @(posedge clk);
        interrupt <= 1'b1;
        wait_bit(2, 1'b1, 10, cyc, ok);
        if (ok) check_word("sync latency", 2, cyc);
        be = 4'b0110;
        @(posedge clk);
        ig_response     <= 1'b1;
        cpu_data_addr   <= 32'h0000_0100;
        cpu_data_byteen <= be;
        @(negedge clk);
        check_word("resp m_int_addr", mips_pkg::int_resp_addr, m_int_addr);
        check_byteen("resp m_int_byteen", be, m_int_byteen);
        @(posedge clk);
        ig_response <= 1'b0;                           // Write still pending
        @(negedge clk);
        check_word("no resp m_int_addr", '0, m_int_addr);
        check_byteen("no resp m_int_byteen", '0, m_int_byteen);
        @(posedge clk);
        interrupt       <= 1'b0;
        cpu_data_byteen <= '0;
        cpu_data_addr   <= idle_addr;
        wait_bit(2, 1'b0, 10, cyc, ok);
        @(posedge clk);
        ig_response     <= 1'b1;                       // Response without interrupt
        cpu_data_addr   <= 32'h0000_0100;
        cpu_data_byteen <= be;
        @(negedge clk);
        check_word("stale m_int_addr", '0, m_int_addr);
        check_byteen("stale m_int_byteen", '0, m_int_byteen);
        @(posedge clk);
        ig_response     <= 1'b0;
        cpu_data_byteen <= '0;
        cpu_data_addr   <= idle_addr;
        end_test();

        @(negedge clk);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* project.f */
hw/mips_pkg.sv
hw/data_bridge.sv
hw/timer_counter.sv
hw/int_collector.sv
hw/mips_periph_top.sv
tb/mips_periph_assertions.sv
tb/tb_mips_periph.sv
